/* design/sysctl_pkg.sv */
`default_nettype none

package sysctl_pkg;

	// CSR bus word types
	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;
	typedef logic [3:0]  csr_bank_t;
	typedef logic [3:0]  csr_reg_t;

	// Bank number sits in the top four address bits
	localparam int CSR_BANK_LSB = 10;

	// System control bank offsets
	localparam csr_reg_t REG_GPIO_IN     = 4'd0;
	localparam csr_reg_t REG_GPIO_OUT    = 4'd1;
	localparam csr_reg_t REG_GPIO_IRQEN  = 4'd2;
	localparam csr_reg_t REG_T0_CTRL     = 4'd4;
	localparam csr_reg_t REG_T0_COMPARE  = 4'd5;
	localparam csr_reg_t REG_T0_COUNTER  = 4'd6;
	localparam csr_reg_t REG_T1_CTRL     = 4'd8;
	localparam csr_reg_t REG_T1_COMPARE  = 4'd9;
	localparam csr_reg_t REG_T1_COUNTER  = 4'd10;
	localparam csr_reg_t REG_SYSTEMID    = 4'd15;

	// Interrupt controller bank offsets
	localparam csr_reg_t REG_IRQ_PENDING = 4'd0;
	localparam csr_reg_t REG_IRQ_MASK    = 4'd1;

	// Timer control word bits
	// Trigger flag is read-only
	localparam int TCTRL_TRIG = 0;
	localparam int TCTRL_AR   = 1;
	localparam int TCTRL_EN   = 2;

	// Interrupt source indices
	localparam int IRQ_GPIO   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_TIMER1 = 2;
	localparam int NIRQ       = 3;

endpackage

`default_nettype wire

/* design/gpio_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_sampler #(
	parameter int ninputs = 16
) (
	input  wire               sys_clk,
	input  wire               sys_rst,

	// Raw pins, asynchronous to sys_clk
	input  wire [ninputs-1:0] gpio_inputs,
	// Per-pin change interrupt enable
	input  wire [ninputs-1:0] irq_en,

	// Synchronized pin state
	output logic [ninputs-1:0] gpio_in,
	output logic               gpio_irq
);

	// First synchronizer stage
	logic [ninputs-1:0] gpio_meta;
	// Sample from the previous cycle
	logic [ninputs-1:0] gpio_prev;
	// Pins whose level moved
	logic [ninputs-1:0] gpio_diff;

	// Two-flop synchronizer
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_inputs;
		gpio_in   <= gpio_meta;
	end

	// Previous sample for edge detection
	always_ff @(posedge sys_clk) begin
		gpio_prev <= gpio_in;
	end

	// Any edge, either polarity
	assign gpio_diff = gpio_in ^ gpio_prev;

	// One-cycle pulse when an enabled pin changed
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			gpio_irq <= 1'b0;
		end else begin
			gpio_irq <= |(gpio_diff & irq_en);
		end
	end

endmodule

`default_nettype wire

/* design/sysctl_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sysctl_timer
	import sysctl_pkg::*;
(
	input  wire       sys_clk,
	input  wire       sys_rst,

	// Register write strobes from the bank decode
	input  wire       wr_ctrl,
	input  wire       wr_compare,
	input  wire       wr_counter,
	input  csr_data_t wr_data,

	// Status for read-back
	output logic      en,
	output logic      ar,
	output logic      trig,
	output csr_data_t compare,
	output csr_data_t counter,

	// Single-cycle interrupt pulse on match
	output logic      irq
);

	logic match;

	assign match = (counter == compare);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			en      <= 1'b0;
			ar      <= 1'b0;
			trig    <= 1'b0;
			irq     <= 1'b0;
			counter <= '0;
			// Far-away compare so a bare enable runs a long time
			compare <= '1;
		end else begin
			irq <= 1'b0;

			// Count up toward compare
			if (en && !match) begin
				counter <= counter + csr_data_t'(1);
			end

			// Match while running
			if (en && match) begin
				trig <= 1'b1;
				irq  <= 1'b1;
				if (ar) begin
					// Restart at 1 so the period is compare cycles
					counter <= csr_data_t'(1);
				end else begin
					// One-shot stops and holds counter
					en <= 1'b0;
				end
			end

			if (wr_compare) begin
				compare <= wr_data;
			end

			// Bus write beats counting
			if (wr_counter) begin
				counter <= wr_data;
			end

			// Control write also acknowledges trig
			if (wr_ctrl) begin
				trig <= 1'b0;
				ar   <= wr_data[TCTRL_AR];
				en   <= wr_data[TCTRL_EN];
			end
		end
	end

endmodule

`default_nettype wire

/* design/sysctl.sv */
`timescale 1ns/1ps
`default_nettype none

module sysctl
	import sysctl_pkg::*;
#(
	parameter int        ninputs  = 16,
	parameter int        noutputs = 16,
	parameter csr_data_t systemid = 32'h5c7a_0001,
	parameter csr_bank_t csr_bank = 4'd0
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst,

	// CSR bus
	input  csr_addr_t           csr_a,
	input  wire                 csr_we,
	input  csr_data_t           csr_di,
	output csr_data_t           csr_do,

	// GPIO pins
	input  wire [ninputs-1:0]   gpio_inputs,
	output logic [noutputs-1:0] gpio_outputs,

	// Interrupt pulses
	output logic                gpio_irq,
	output logic                timer0_irq,
	output logic                timer1_irq
);

	// Bank and register decode
	logic      csr_selected;
	logic      csr_wr;
	csr_reg_t  csr_reg;

	// GPIO state
	logic [ninputs-1:0] gpio_in;
	logic [ninputs-1:0] gpio_irqen;

	// Timer strobes and status
	logic      t0_wr_ctrl;
	logic      t0_wr_compare;
	logic      t0_wr_counter;
	logic      t0_en;
	logic      t0_ar;
	logic      t0_trig;
	csr_data_t t0_compare;
	csr_data_t t0_counter;
	logic      t1_wr_ctrl;
	logic      t1_wr_compare;
	logic      t1_wr_counter;
	logic      t1_en;
	logic      t1_ar;
	logic      t1_trig;
	csr_data_t t1_compare;
	csr_data_t t1_counter;

	// Timer control word as seen on the bus
	function automatic csr_data_t pack_ctrl(input logic en, input logic ar, input logic trig);
		csr_data_t word;
		word             = '0;
		word[TCTRL_EN]   = en;
		word[TCTRL_AR]   = ar;
		word[TCTRL_TRIG] = trig;
		return word;
	endfunction

	assign csr_selected = (csr_a[CSR_BANK_LSB +: $bits(csr_bank_t)] == csr_bank);
	assign csr_reg      = csr_a[$bits(csr_reg_t)-1:0];
	assign csr_wr       = csr_selected && csr_we;

	// Timer write strobes, one per register
	assign t0_wr_ctrl    = csr_wr && (csr_reg == REG_T0_CTRL);
	assign t0_wr_compare = csr_wr && (csr_reg == REG_T0_COMPARE);
	assign t0_wr_counter = csr_wr && (csr_reg == REG_T0_COUNTER);
	assign t1_wr_ctrl    = csr_wr && (csr_reg == REG_T1_CTRL);
	assign t1_wr_compare = csr_wr && (csr_reg == REG_T1_COMPARE);
	assign t1_wr_counter = csr_wr && (csr_reg == REG_T1_COUNTER);

	gpio_sampler #(
		.ninputs(ninputs)
	) u_gpio_sampler (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.gpio_inputs(gpio_inputs),
		.irq_en     (gpio_irqen),
		.gpio_in    (gpio_in),
		.gpio_irq   (gpio_irq)
	);

	sysctl_timer u_timer0 (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.wr_ctrl   (t0_wr_ctrl),
		.wr_compare(t0_wr_compare),
		.wr_counter(t0_wr_counter),
		.wr_data   (csr_di),
		.en        (t0_en),
		.ar        (t0_ar),
		.trig      (t0_trig),
		.compare   (t0_compare),
		.counter   (t0_counter),
		.irq       (timer0_irq)
	);

	sysctl_timer u_timer1 (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.wr_ctrl   (t1_wr_ctrl),
		.wr_compare(t1_wr_compare),
		.wr_counter(t1_wr_counter),
		.wr_data   (csr_di),
		.en        (t1_en),
		.ar        (t1_ar),
		.trig      (t1_trig),
		.compare   (t1_compare),
		.counter   (t1_counter),
		.irq       (timer1_irq)
	);

	// GPIO registers, GPIO_IN is read-only
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			gpio_outputs <= '0;
			gpio_irqen   <= '0;
		end else if (csr_wr) begin
			if (csr_reg == REG_GPIO_OUT) begin
				gpio_outputs <= csr_di[noutputs-1:0];
			end
			if (csr_reg == REG_GPIO_IRQEN) begin
				gpio_irqen <= csr_di[ninputs-1:0];
			end
		end
	end

	// Registered read data, zero when another bank is addressed
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (csr_selected) begin
				case (csr_reg)
					REG_GPIO_IN:    csr_do <= csr_data_t'(gpio_in);
					REG_GPIO_OUT:   csr_do <= csr_data_t'(gpio_outputs);
					REG_GPIO_IRQEN: csr_do <= csr_data_t'(gpio_irqen);
					REG_T0_CTRL:    csr_do <= pack_ctrl(t0_en, t0_ar, t0_trig);
					REG_T0_COMPARE: csr_do <= t0_compare;
					REG_T0_COUNTER: csr_do <= t0_counter;
					REG_T1_CTRL:    csr_do <= pack_ctrl(t1_en, t1_ar, t1_trig);
					REG_T1_COMPARE: csr_do <= t1_compare;
					REG_T1_COUNTER: csr_do <= t1_counter;
					REG_SYSTEMID:   csr_do <= systemid;
					// Holes read zero
					default:        csr_do <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/irq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
	import sysctl_pkg::*;
#(
	parameter int        nirq     = NIRQ,
	parameter csr_bank_t csr_bank = 4'd1
) (
	input  wire            sys_clk,
	input  wire            sys_rst,

	// CSR bus
	input  csr_addr_t      csr_a,
	input  wire            csr_we,
	input  csr_data_t      csr_di,
	output csr_data_t      csr_do,

	// One pulse per event
	input  wire [nirq-1:0] irq_sources,
	output logic           cpu_irq
);

	logic            csr_selected;
	csr_reg_t        csr_reg;
	logic [nirq-1:0] pending;
	logic [nirq-1:0] mask;
	// Write-one-to-clear bits for this cycle
	logic [nirq-1:0] ack;

	assign csr_selected = (csr_a[CSR_BANK_LSB +: $bits(csr_bank_t)] == csr_bank);
	assign csr_reg      = csr_a[$bits(csr_reg_t)-1:0];

	assign ack = (csr_selected && csr_we && (csr_reg == REG_IRQ_PENDING))
		? csr_di[nirq-1:0] : '0;

	// Pending latch, a new pulse wins over a clear
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~ack) | irq_sources;
		end
	end

	// Mask register
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			mask <= '0;
		end else if (csr_selected && csr_we && (csr_reg == REG_IRQ_MASK)) begin
			mask <= csr_di[nirq-1:0];
		end
	end

	// Level to the CPU, one register after pending
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cpu_irq <= 1'b0;
		end else begin
			cpu_irq <= |(pending & mask);
		end
	end

	// Read data
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (csr_selected) begin
				case (csr_reg)
					REG_IRQ_PENDING: csr_do <= csr_data_t'(pending);
					REG_IRQ_MASK:    csr_do <= csr_data_t'(mask);
					default:         csr_do <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/sysctl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sysctl_top
	import sysctl_pkg::*;
#(
	parameter int        ninputs     = 16,
	parameter int        noutputs    = 16,
	parameter csr_data_t systemid    = 32'h5c7a_0001,
	parameter csr_bank_t sysctl_bank = 4'd0,
	parameter csr_bank_t irq_bank    = 4'd1
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst,

	// Shared CSR bus
	input  csr_addr_t           csr_a,
	input  wire                 csr_we,
	input  csr_data_t           csr_di,
	output csr_data_t           csr_do,

	input  wire [ninputs-1:0]   gpio_inputs,
	output logic [noutputs-1:0] gpio_outputs,

	output logic                cpu_irq
);

	// Per-bank read data
	csr_data_t       sysctl_do;
	csr_data_t       irq_do;

	// Interrupt pulses from the system control bank
	logic            gpio_irq;
	logic            timer0_irq;
	logic            timer1_irq;
	logic [NIRQ-1:0] irq_sources;

	// Source order follows the IRQ index constants
	assign irq_sources[IRQ_GPIO]   = gpio_irq;
	assign irq_sources[IRQ_TIMER0] = timer0_irq;
	assign irq_sources[IRQ_TIMER1] = timer1_irq;

	// Unselected banks drive zero
	assign csr_do = sysctl_do | irq_do;

	sysctl #(
		.ninputs (ninputs),
		.noutputs(noutputs),
		.systemid(systemid),
		.csr_bank(sysctl_bank)
	) u_sysctl (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.csr_a       (csr_a),
		.csr_we      (csr_we),
		.csr_di      (csr_di),
		.csr_do      (sysctl_do),
		.gpio_inputs (gpio_inputs),
		.gpio_outputs(gpio_outputs),
		.gpio_irq    (gpio_irq),
		.timer0_irq  (timer0_irq),
		.timer1_irq  (timer1_irq)
	);

	irq_ctrl #(
		.nirq    (NIRQ),
		.csr_bank(irq_bank)
	) u_irq_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.csr_a      (csr_a),
		.csr_we     (csr_we),
		.csr_di     (csr_di),
		.csr_do     (irq_do),
		.irq_sources(irq_sources),
		.cpu_irq    (cpu_irq)
	);

endmodule

`default_nettype wire

/* verif/sysctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sysctl_tb
	import sysctl_pkg::*;
();

	localparam int        POLL_LIMIT = 200;
	localparam int        MAX_OPS    = 96;
	// Default ID word of sysctl_top
	localparam csr_data_t SYSID      = 32'h5c7a_0001;
	localparam csr_bank_t SYS_BANK   = 4'd0;
	localparam csr_bank_t IRQ_BANK   = 4'd1;
	// Nobody decodes this bank
	localparam csr_bank_t NO_BANK    = 4'd2;

	// Operation kinds
	localparam int OP_WRITE = 0;
	localparam int OP_READ  = 1;
	localparam int OP_POLL  = 2;
	// Drive gpio_inputs with the data field
	localparam int OP_PINS  = 3;
	// Compare cpu_irq
	localparam int OP_IRQ   = 4;
	// Compare gpio_outputs
	localparam int OP_GOUT  = 5;

	logic        sys_clk;
	logic        sys_rst;
	csr_addr_t   csr_a;
	logic        csr_we;
	csr_data_t   csr_di;
	csr_data_t   csr_do;
	logic [15:0] gpio_inputs;
	logic [15:0] gpio_outputs;
	logic        cpu_irq;

	// Operation table
	int          op_kind [MAX_OPS];
	csr_addr_t   op_addr [MAX_OPS];
	csr_data_t   op_data [MAX_OPS];
	csr_data_t   op_exp  [MAX_OPS];
	csr_data_t   op_mask [MAX_OPS];
	int          n_ops;

	sysctl_top UUT (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.csr_a       (csr_a),
		.csr_we      (csr_we),
		.csr_di      (csr_di),
		.csr_do      (csr_do),
		.gpio_inputs (gpio_inputs),
		.gpio_outputs(gpio_outputs),
		.cpu_irq     (cpu_irq)
	);

	// 100 MHz
	always #5 sys_clk = ~sys_clk;

	// Bank in the top four bits, register in the bottom four
	function automatic csr_addr_t reg_addr(input csr_bank_t bank, input csr_reg_t offset);
		return csr_addr_t'({bank, 6'b0, offset});
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped at the first failed check");
	endtask

	task automatic add_op(input int kind, input csr_addr_t addr, input csr_data_t data,
		input csr_data_t exp, input csr_data_t mask);
		op_kind[n_ops] = kind;
		op_addr[n_ops] = addr;
		op_data[n_ops] = data;
		op_exp[n_ops]  = exp;
		op_mask[n_ops] = mask;
		n_ops++;
	endtask

	// One bus cycle, ends 1 ns after the edge
	task automatic bus_write(input csr_addr_t addr, input csr_data_t data);
		csr_a  = addr;
		csr_we = 1'b1;
		csr_di = data;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	// Read data is registered, valid just after the next edge
	task automatic bus_read(input csr_addr_t addr, output csr_data_t data);
		csr_a  = addr;
		csr_we = 1'b0;
		@(posedge sys_clk);
		#1;
		data = csr_do;
	endtask

	task automatic check_value(input int idx, input csr_data_t actual);
		csr_data_t got;
		got = actual & op_mask[idx];
		assert (got == op_exp[idx]) else
			stop_on_error($sformatf("MISMATCH at %0t: step %0d addr %h expected %h got %h",
				$time, idx, op_addr[idx], op_exp[idx], got));
	endtask

	task automatic build_table();
		csr_data_t r0;
		csr_data_t r1;
		csr_data_t r2;
		csr_data_t r3;
		csr_data_t r4;
		csr_data_t r5;
		csr_data_t r6;
		csr_data_t r7;
		r0 = $urandom;
		r1 = $urandom;
		r2 = $urandom;
		r3 = $urandom;
		r4 = $urandom;
		r5 = $urandom;
		r6 = $urandom;
		r7 = $urandom;
		n_ops = 0;

		// Reset state
		add_op(OP_GOUT, '0, '0, '0, 32'h0000_ffff);
		add_op(OP_IRQ, '0, '0, '0, 32'h1);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T0_COMPARE), '0, '1, '1);

		// Read-back, truncated to 16 GPIO bits and 3 IRQ bits
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_GPIO_OUT), r0, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_GPIO_OUT), '0, r0 & 32'hffff, '1);
		add_op(OP_GOUT, '0, '0, r0 & 32'hffff, 32'h0000_ffff);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_GPIO_IRQEN), r1, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_GPIO_IRQEN), '0, r1 & 32'hffff, '1);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_GPIO_IRQEN), '0, '0, '0);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T0_COMPARE), r2, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T0_COMPARE), '0, r2, '1);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T0_COUNTER), r3, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T0_COUNTER), '0, r3, '1);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T1_COMPARE), r4, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T1_COMPARE), '0, r4, '1);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T1_COUNTER), r5, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T1_COUNTER), '0, r5, '1);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_MASK), r6, '0, '0);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_MASK), '0, r6 & 32'h7, '1);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_MASK), '0, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_SYSTEMID), '0, SYSID, '1);
		// Hole at offset 3 ignores writes
		add_op(OP_WRITE, reg_addr(SYS_BANK, 4'd3), r7, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, 4'd3), '0, '0, '1);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_GPIO_OUT), '0, r0 & 32'hffff, '1);
		add_op(OP_READ, reg_addr(NO_BANK, 4'd0), '0, '0, '1);

		// GPIO sampling, no pin enabled yet
		add_op(OP_PINS, '0, 32'h3c5a, '0, '0);
		add_op(OP_POLL, reg_addr(SYS_BANK, REG_GPIO_IN), '0, 32'h3c5a, 32'hffff);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h7, '0, '0);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, '0, 32'h1);
		// Pin 4 enabled and toggled
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_GPIO_IRQEN), 32'h0010, '0, '0);
		add_op(OP_PINS, '0, 32'h3c4a, '0, '0);
		add_op(OP_POLL, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, 32'h1, 32'h1);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h1, '0, '0);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, '0, 32'h1);
		// Pin 8 toggles but is masked
		add_op(OP_PINS, '0, 32'h3d4a, '0, '0);
		add_op(OP_POLL, reg_addr(SYS_BANK, REG_GPIO_IN), '0, 32'h3d4a, 32'hffff);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, '0, 32'h1);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, '0, 32'h1);

		// Timer 0 one-shot to 20
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h7, '0, '0);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T0_COUNTER), '0, '0, '0);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T0_COMPARE), 32'd20, '0, '0);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T0_CTRL), 32'h1 << TCTRL_EN, '0, '0);
		add_op(OP_POLL, reg_addr(SYS_BANK, REG_T0_CTRL), '0, 32'h1 << TCTRL_TRIG,
			32'h1 << TCTRL_TRIG);
		// Trig only, enable dropped
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T0_CTRL), '0, 32'h1 << TCTRL_TRIG, '1);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T0_COUNTER), '0, 32'd20, '1);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, 32'h1 << IRQ_TIMER0,
			32'h1 << IRQ_TIMER0);

		// Timer 1 autoreload, period 10
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T1_COUNTER), '0, '0, '0);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T1_COMPARE), 32'd10, '0, '0);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h1 << IRQ_TIMER1, '0, '0);
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T1_CTRL),
			(32'h1 << TCTRL_AR) | (32'h1 << TCTRL_EN), '0, '0);
		add_op(OP_POLL, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, 32'h1 << IRQ_TIMER1,
			32'h1 << IRQ_TIMER1);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h1 << IRQ_TIMER1, '0, '0);
		// Next match is still several cycles away
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, '0, 32'h1 << IRQ_TIMER1);
		add_op(OP_POLL, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, 32'h1 << IRQ_TIMER1,
			32'h1 << IRQ_TIMER1);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T1_CTRL), '0, 32'h7, '1);
		// Control write drops trig
		add_op(OP_WRITE, reg_addr(SYS_BANK, REG_T1_CTRL), '0, '0, '0);
		add_op(OP_READ, reg_addr(SYS_BANK, REG_T1_CTRL), '0, '0, '1);

		// Masking, only the timer 0 bit left pending
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h1 << IRQ_TIMER1, '0, '0);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, 32'h1 << IRQ_TIMER0, '1);
		add_op(OP_IRQ, '0, '0, '0, 32'h1);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_MASK), 32'h1 << IRQ_TIMER0, '0, '0);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_MASK), '0, 32'h1 << IRQ_TIMER0, '1);
		add_op(OP_IRQ, '0, '0, 32'h1, 32'h1);
		add_op(OP_WRITE, reg_addr(IRQ_BANK, REG_IRQ_PENDING), 32'h1 << IRQ_TIMER0, '0, '0);
		add_op(OP_READ, reg_addr(IRQ_BANK, REG_IRQ_PENDING), '0, '0, '1);
		add_op(OP_IRQ, '0, '0, '0, 32'h1);
	endtask

	initial begin
		csr_data_t   rd;
		int          tries;
		int unsigned seed;
		sys_clk     = 1'b0;
		sys_rst     = 1'b1;
		csr_a       = '0;
		csr_we      = 1'b0;
		csr_di      = '0;
		gpio_inputs = '0;
		seed        = 32'hf48a_4ec8;
		void'($urandom(seed));
		build_table();

		// Reset for 4 cycles, released just after an edge
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		for (int i = 0; i < n_ops; i++) begin
			case (op_kind[i])
				OP_WRITE: bus_write(op_addr[i], op_data[i]);
				OP_READ: begin
					bus_read(op_addr[i], rd);
					check_value(i, rd);
				end
				OP_POLL: begin
					tries = 1;
					bus_read(op_addr[i], rd);
					while (((rd & op_mask[i]) != op_exp[i]) && (tries < POLL_LIMIT)) begin
						bus_read(op_addr[i], rd);
						tries++;
					end
					assert ((rd & op_mask[i]) == op_exp[i]) else
						stop_on_error($sformatf(
							"Poll at step %0d on address %h never saw %h within %0d cycles",
							i, op_addr[i], op_exp[i], POLL_LIMIT));
				end
				OP_PINS: gpio_inputs = op_data[i][15:0];
				OP_IRQ: check_value(i, csr_data_t'(cpu_irq));
				OP_GOUT: check_value(i, csr_data_t'(gpio_outputs));
				default: stop_on_error($sformatf("Unknown operation kind at step %0d", i));
			endcase
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
design/sysctl_pkg.sv
design/gpio_sampler.sv
design/sysctl_timer.sv
design/sysctl.sv
design/irq_ctrl.sv
design/sysctl_top.sv
verif/sysctl_tb.sv
